//--- source/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register index width
`define REG_WIDTH 5

// Architectural registers, x0 included
`define REG_COUNT 32

`endif

//--- source/rv_core_pkg.sv
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        op_r      = 7'b0110011,         // add sub and or slt
        op_imm    = 7'b0010011,         // addi
        op_load   = 7'b0000011,         // lw
        op_store  = 7'b0100011,         // sw
        op_branch = 7'b1100011          // beq
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_mem = 2'd1,                 // Load data
        res_pc4 = 2'd2                  // Link value
    } result_src_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_WIDTH-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [`REG_WIDTH-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;  // imm[11:5]
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;  // imm[4:0]
        opcode_e               opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`REG_WIDTH-1:0] rs2;
        logic [`REG_WIDTH-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_fmt_t;

    // One instruction word in four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

//--- source/decoder.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module decoder import rv_core_pkg::*; (
    input  instr_u            instr,
    output logic              reg_write,
    output logic              mem_write,
    output logic              branch,
    output logic              alu_src,
    output result_src_e       result_src,
    output alu_op_e           alu_op,
    output logic [`XLEN-1:0]  imm
);

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;     // lw and sw
    localparam logic [2:0] F3_BEQ     = 3'b000;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;

    assign imm_i = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{(`XLEN-12){instr.s_fmt.imm_hi[6]}},
                    instr.s_fmt.imm_hi,
                    instr.s_fmt.imm_lo};
    assign imm_b = {{(`XLEN-13){instr.b_fmt.imm_12}},
                    instr.b_fmt.imm_12,
                    instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5,
                    instr.b_fmt.imm_4_1,
                    1'b0};                          // Halfword aligned offset

    always_comb begin
        reg_write  = 1'b0;                          // Nop unless recognised
        mem_write  = 1'b0;
        branch     = 1'b0;
        alu_src    = 1'b0;
        result_src = res_alu;
        alu_op     = alu_add;
        imm        = '0;

        case (instr.r_fmt.opcode)
            op_r: begin
                reg_write = 1'b1;
                case (instr.r_fmt.funct3)
                    F3_ADD_SUB: alu_op = instr.r_fmt.funct7[5] ? alu_sub : alu_add;
                    F3_SLT:     alu_op = alu_slt;
                    F3_OR:      alu_op = alu_or;
                    F3_AND:     alu_op = alu_and;
                    default:    reg_write = 1'b0;   // Unsupported R-type
                endcase
            end
            op_imm: begin
                reg_write = (instr.i_fmt.funct3 == F3_ADD_SUB);    // addi only
                alu_src   = 1'b1;
                imm       = imm_i;
            end
            op_load: begin
                reg_write  = (instr.i_fmt.funct3 == F3_WORD);
                alu_src    = 1'b1;
                result_src = res_mem;
                imm        = imm_i;
            end
            op_store: begin
                mem_write = (instr.s_fmt.funct3 == F3_WORD);
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            op_branch: begin
                branch = (instr.b_fmt.funct3 == F3_BEQ);
                alu_op = alu_sub;                   // Equal when difference is zero
                imm    = imm_b;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [`REG_WIDTH-1:0]  ra1,
    input  logic [`REG_WIDTH-1:0]  ra2,
    input  logic [`REG_WIDTH-1:0]  wa,
    input  logic [`XLEN-1:0]       wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];     // x0 is not stored

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd1 = (ra1 == '0)             ? '0 :
                 (we && (ra1 == wa))     ? wd : regs[ra1];
    assign rd2 = (ra2 == '0)             ? '0 :
                 (we && (ra2 == wa))     ? wd : regs[ra2];

endmodule

//--- source/alu.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module alu import rv_core_pkg::*; (
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  alu_op_e           op,
    output logic [`XLEN-1:0]  y,
    output logic              zero
);

    logic slt;

    assign slt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_slt: y = {{(`XLEN-1){1'b0}}, slt};     // Signed compare
            default: y = a + b;
        endcase
    end

    assign zero = (y == '0);                          // beq condition

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module hazard_unit import rv_core_pkg::*; (
    input  logic [`REG_WIDTH-1:0]  rs1_d,
    input  logic [`REG_WIDTH-1:0]  rs2_d,
    input  logic [`REG_WIDTH-1:0]  rs1_e,
    input  logic [`REG_WIDTH-1:0]  rs2_e,
    input  logic [`REG_WIDTH-1:0]  rd_e,
    input  logic [`REG_WIDTH-1:0]  rd_m,           // Memory stage destination
    input  logic [`REG_WIDTH-1:0]  rd_w,           // Writeback stage destination
    input  logic                   reg_write_m,
    input  logic                   reg_write_w,
    input  logic [1:0]             result_src_e,
    input  logic                   pc_src,         // Taken branch in execute
    output logic [1:0]             forward_a,
    output logic [1:0]             forward_b,
    output logic                   stall_f,
    output logic                   stall_d,
    output logic                   flush_d,
    output logic                   flush_e
);

    logic lw_stall;

    // Newest producer wins and x0 is never forwarded
    function automatic logic [1:0] fwd_sel(
        input logic [`REG_WIDTH-1:0] rs,
        input logic [`REG_WIDTH-1:0] mem_rd,
        input logic                  mem_we,
        input logic [`REG_WIDTH-1:0] wb_rd,
        input logic                  wb_we
    );
        if (mem_we && (rs == mem_rd) && (rs != '0)) begin
            return 2'b10;
        end else if (wb_we && (rs == wb_rd) && (rs != '0)) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign forward_a = fwd_sel(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
    assign forward_b = fwd_sel(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

    // Load in execute feeding the instruction in decode
    assign lw_stall = (result_src_e == res_mem) && (rd_e != '0) &&
                      ((rd_e == rs1_d) || (rd_e == rs2_d));

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src;                       // Wrong-path fetch
    assign flush_e = lw_stall || pc_src;           // Bubble or wrong-path decode

endmodule

//--- source/rv_core.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic [`XLEN-1:0]   imem_rdata,
    output logic [`XLEN-1:0]   dmem_addr,
    output logic [`XLEN-1:0]   dmem_wdata,
    output logic               dmem_we,
    input  logic [`XLEN-1:0]   dmem_rdata
);

    // Fetch
    logic [`XLEN-1:0]      pc_f;
    logic [`XLEN-1:0]      pc_plus4_f;
    logic [`XLEN-1:0]      pc_next_f;

    // Decode
    instr_u                instr_d;
    logic [`XLEN-1:0]      pc_d;
    logic                  reg_write_d;
    logic                  mem_write_d;
    logic                  branch_d;
    logic                  alu_src_d;
    result_src_e           res_src_d;
    alu_op_e               alu_ctl_d;
    logic [`XLEN-1:0]      imm_d;
    logic [`XLEN-1:0]      rd1_d;
    logic [`XLEN-1:0]      rd2_d;

    // Execute
    logic                  reg_write_e;
    logic                  mem_write_e;
    logic                  branch_e;
    logic                  alu_src_e;
    result_src_e           res_src_e;
    alu_op_e               alu_ctl_e;
    logic [`XLEN-1:0]      rd1_e;
    logic [`XLEN-1:0]      rd2_e;
    logic [`XLEN-1:0]      pc_e;
    logic [`XLEN-1:0]      imm_e;
    logic [`REG_WIDTH-1:0] rs1_e;
    logic [`REG_WIDTH-1:0] rs2_e;
    logic [`REG_WIDTH-1:0] rd_e;
    logic [`XLEN-1:0]      src_a_e;
    logic [`XLEN-1:0]      src_b_e;
    logic [`XLEN-1:0]      write_data_e;
    logic [`XLEN-1:0]      alu_result_e;
    logic                  zero_e;
    logic [`XLEN-1:0]      pc_target_e;
    logic                  pc_src;

    // Memory
    logic                  reg_write_m;
    logic                  mem_write_m;
    result_src_e           res_src_m;
    logic [`XLEN-1:0]      alu_result_m;
    logic [`XLEN-1:0]      write_data_m;
    logic [`REG_WIDTH-1:0] rd_m;

    // Writeback
    logic                  reg_write_w;
    result_src_e           res_src_w;
    logic [`XLEN-1:0]      alu_result_w;
    logic [`XLEN-1:0]      read_data_w;
    logic [`REG_WIDTH-1:0] rd_w;
    logic [`XLEN-1:0]      result_w;

    // Hazard control
    logic [1:0]            forward_a;
    logic [1:0]            forward_b;
    logic                  stall_f;
    logic                  stall_d;
    logic                  flush_d;
    logic                  flush_e;

    function automatic logic [`XLEN-1:0] operand_mux(
        input logic [1:0]       sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            2'b10:   return mem_val;
            2'b01:   return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign pc_plus4_f = pc_f + `XLEN'd4;
    assign pc_next_f  = pc_src ? pc_target_e : pc_plus4_f;   // Redirect on taken beq
    assign imem_addr  = pc_f;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_f <= '0;
        end else if (!stall_f) begin
            pc_f <= pc_next_f;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_d) begin
            instr_d <= '0;                  // Opcode zero decodes as a nop
        end else if (!stall_d) begin
            instr_d <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d <= pc_f;
        end
    end

    decoder decoder_i (
        .instr      (instr_d),
        .reg_write  (reg_write_d),
        .mem_write  (mem_write_d),
        .branch     (branch_d),
        .alu_src    (alu_src_d),
        .result_src (res_src_d),
        .alu_op     (alu_ctl_d),
        .imm        (imm_d)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (reg_write_w),
        .ra1   (instr_d.r_fmt.rs1),
        .ra2   (instr_d.r_fmt.rs2),
        .wa    (rd_w),
        .wd    (result_w),
        .rd1   (rd1_d),
        .rd2   (rd2_d)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || flush_e) begin
            reg_write_e <= 1'b0;
            mem_write_e <= 1'b0;
            branch_e    <= 1'b0;
            res_src_e   <= res_alu;         // Also hides a stale load from hazard checks
        end else begin
            reg_write_e <= reg_write_d;
            mem_write_e <= mem_write_d;
            branch_e    <= branch_d;
            res_src_e   <= res_src_d;
        end
    end

    always_ff @(posedge clk) begin
        alu_src_e  <= alu_src_d;
        alu_ctl_e  <= alu_ctl_d;
        rd1_e      <= rd1_d;
        rd2_e      <= rd2_d;
        pc_e       <= pc_d;
        imm_e      <= imm_d;
        rs1_e      <= instr_d.r_fmt.rs1;
        rs2_e      <= instr_d.r_fmt.rs2;
        rd_e       <= instr_d.r_fmt.rd;
    end

    assign src_a_e      = operand_mux(forward_a, rd1_e, alu_result_m, result_w);
    assign write_data_e = operand_mux(forward_b, rd2_e, alu_result_m, result_w);
    assign src_b_e      = alu_src_e ? imm_e : write_data_e;

    alu alu_i (
        .a    (src_a_e),
        .b    (src_b_e),
        .op   (alu_ctl_e),
        .y    (alu_result_e),
        .zero (zero_e)
    );

    assign pc_target_e = pc_e + imm_e;
    assign pc_src      = branch_e && zero_e;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_m <= 1'b0;
            mem_write_m <= 1'b0;
            res_src_m   <= res_alu;
        end else begin
            reg_write_m <= reg_write_e;
            mem_write_m <= mem_write_e;
            res_src_m   <= res_src_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;       // Forwarded store data
        rd_m         <= rd_e;
    end

    assign dmem_addr  = alu_result_m;
    assign dmem_wdata = write_data_m;
    assign dmem_we    = mem_write_m;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_w <= 1'b0;
            res_src_w   <= res_alu;
        end else begin
            reg_write_w <= reg_write_m;
            res_src_w   <= res_src_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= dmem_rdata;
        rd_w         <= rd_m;
    end

    always_comb begin
        case (res_src_w)
            res_mem: result_w = read_data_w;
            default: result_w = alu_result_w;
        endcase
    end

    hazard_unit hazard_unit_i (
        .rs1_d        (instr_d.r_fmt.rs1),
        .rs2_d        (instr_d.r_fmt.rs2),
        .rs1_e        (rs1_e),
        .rs2_e        (rs2_e),
        .rd_e         (rd_e),
        .rd_m         (rd_m),
        .rd_w         (rd_w),
        .reg_write_m  (reg_write_m),
        .reg_write_w  (reg_write_w),
        .result_src_e (res_src_e),
        .pc_src       (pc_src),
        .forward_a    (forward_a),
        .forward_b    (forward_b),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .flush_d      (flush_d),
        .flush_e      (flush_e)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 50          // 100 ns clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- tests/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module tb_rv_core;

    localparam logic [31:0] END_ADDR = 32'h0000_00fc;
    localparam int          MAX_WAIT = 2000;

    logic               clk;
    logic               rst_n;
    logic [`XLEN-1:0]   imem_addr;
    logic [`XLEN-1:0]   imem_rdata;
    logic [`XLEN-1:0]   dmem_addr;
    logic [`XLEN-1:0]   dmem_wdata;
    logic               dmem_we;
    logic [`XLEN-1:0]   dmem_rdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [0:63];           // Reference store trace
    logic [31:0] exp_data [0:63];
    int          exp_count;
    int          prog_len;
    logic [31:0] lfsr_state;
    int          store_idx;
    int          mon_errors;
    logic        end_seen;
    int          pass_count;
    int          fail_count;

    tb_clock_gen clock_gen_i (
        .clk (clk)
    );

    rv_core rv_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = rst_n ? dmem[dmem_addr[7:2]] : '0;

    // Power-up data contents distinct for every word
    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return 32'hc3a5_0000 ^ ({26'd0, idx} * 32'h0104_0821);
    endfunction

    // kind 0 add, 1 sub, 2 and, 3 or, 4 slt
    function automatic logic [31:0] r_word(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (kind == 1) ? 7'h20 : 7'h00;
        case (kind)
            2:       f3 = 3'd7;
            3:       f3 = 3'd6;
            4:       f3 = 3'd2;
            default: f3 = 3'd0;
        endcase
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Executes imem one instruction at a time and records every store
    function automatic int run_reference();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:63];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        logic        done;
        int          n;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i[5:0]] = fill_word(i[5:0]);
        end
        pc    = '0;
        done  = 1'b0;
        n     = 0;
        steps = 0;
        while (!done && steps < 4000) begin
            w       = imem[pc[9:2]];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            res     = '0;
            wr      = 1'b0;
            next_pc = pc + 32'd4;
            case (w[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case (w[14:12])
                        3'd0:    res = w[30] ? a - b : a + b;
                        3'd2:    res = {31'd0, $signed(a) < $signed(b)};
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr  = (w[14:12] == 3'd0);
                    res = a + {{20{w[31]}}, w[31:20]};
                end
                7'b0000011: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    wr   = (w[14:12] == 3'd2);
                    res  = mem[addr[7:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    if ((w[14:12] == 3'd2) && (n < 64)) begin
                        exp_addr[n[5:0]] = addr;
                        exp_data[n[5:0]] = b;
                        n++;
                        mem[addr[7:2]] = b;
                        done = (addr == END_ADDR);          // End marker reached
                    end
                end
                7'b1100011: begin
                    if ((w[14:12] == 3'd0) && (a == b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            if (wr && (w[11:7] != 5'd0)) begin
                regs[w[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i[5:0]] <= fill_word(i[5:0]);
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // Each store strobe against the next entry of the reference trace
    always @(posedge clk) begin : store_check
        int bad;
        bad = 0;
        if (!rst_n) begin
            store_idx  <= 0;
            mon_errors <= 0;
            end_seen   <= 1'b0;
        end else if (dmem_we) begin
            if (store_idx >= exp_count) begin
                $display("ERROR at %0t: extra store to address %h beyond the expected trace",
                         $time, dmem_addr);
                bad = 1;
            end else begin
                if (dmem_addr !== exp_addr[store_idx[5:0]]) begin
                    $display("ERROR at %0t: dmem_addr expected %h, got %h",
                             $time, exp_addr[store_idx[5:0]], dmem_addr);
                    bad++;
                end
                if (dmem_wdata !== exp_data[store_idx[5:0]]) begin
                    $display("ERROR at %0t: dmem_wdata expected %h, got %h",
                             $time, exp_data[store_idx[5:0]], dmem_wdata);
                    bad++;
                end
            end
            store_idx  <= store_idx + 1;
            mon_errors <= mon_errors + bad;
            if (dmem_addr == END_ADDR) begin
                end_seen <= 1'b1;
            end
        end
    end

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = '0;              // Opcode zero runs as a nop
        end
        prog_len = 0;
    endtask

    task automatic begin_test();
        @(negedge clk);
        rst_n = 1'b0;
        clear_program();
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic emit_end();
        emit(sw_word(5'd0, 5'd0, 12'h0fc));
        emit(beq_word(5'd0, 5'd0, 13'd0));  // Spin here
    endtask

    task automatic run_program(input string name);
        int cycles;
        int errors;
        exp_count = run_reference();
        repeat (16) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!end_seen && (cycles < MAX_WAIT)) begin
            @(negedge clk);
            cycles++;
        end
        errors = 0;
        if (!end_seen) begin
            $display("Test %0s: program never reached its end marker within %0d cycles",
                     name, MAX_WAIT);
            errors++;
        end else if (store_idx != exp_count) begin
            $display("ERROR at %0t: store count expected %0d, got %0d",
                     $time, exp_count, store_idx);
            errors++;
        end
        errors += mon_errors;
        if (errors == 0) begin
            pass_count++;
            $display("Test %0s: passed", name);
        end else begin
            fail_count++;
            $display("Test %0s: failed with %0d errors", name, errors);
        end
    endtask

    task automatic forwarding_program();
        emit(addi_word(5'd1, 5'd0, 12'd5));
        emit(addi_word(5'd2, 5'd1, 12'd7));     // x1 from memory stage
        emit(r_word(0, 5'd3, 5'd1, 5'd2));      // x1 from writeback
        emit(r_word(1, 5'd4, 5'd3, 5'd1));
        emit(r_word(2, 5'd5, 5'd4, 5'd3));
        emit(r_word(3, 5'd6, 5'd5, 5'd2));
        emit(addi_word(5'd8, 5'd0, 12'hffd));   // -3
        emit(r_word(4, 5'd9, 5'd8, 5'd1));
        emit(r_word(4, 5'd7, 5'd1, 5'd8));
        emit(r_word(0, 5'd10, 5'd3, 5'd4));
        emit(sw_word(5'd10, 5'd0, 12'd0));      // Store data forwarded
        emit(addi_word(5'd11, 5'd0, 12'd64));
        emit(sw_word(5'd6, 5'd11, 12'd4));      // Base forwarded
        emit(sw_word(5'd3, 5'd0, 12'd8));
        emit(sw_word(5'd4, 5'd0, 12'd12));
        emit(sw_word(5'd5, 5'd0, 12'd16));
        emit(sw_word(5'd7, 5'd0, 12'd20));
        emit(sw_word(5'd9, 5'd0, 12'd24));
        emit_end();
    endtask

    task automatic load_use_program();
        emit(lw_word(5'd1, 5'd0, 12'd16));
        emit(r_word(0, 5'd2, 5'd1, 5'd1));      // One stall cycle
        emit(lw_word(5'd3, 5'd0, 12'd20));
        emit(sw_word(5'd3, 5'd0, 12'd32));      // Loaded value as store data
        emit(lw_word(5'd4, 5'd0, 12'd24));
        emit(addi_word(5'd5, 5'd4, 12'd1));
        emit(lw_word(5'd7, 5'd0, 12'd32));
        emit(sw_word(5'd2, 5'd0, 12'd36));
        emit(sw_word(5'd5, 5'd0, 12'd40));
        emit(sw_word(5'd7, 5'd0, 12'd44));
        emit_end();
    endtask

    task automatic branch_program();
        emit(addi_word(5'd1, 5'd0, 12'd1));
        emit(addi_word(5'd2, 5'd0, 12'd1));
        emit(beq_word(5'd1, 5'd2, 13'd12));     // Taken
        emit(sw_word(5'd1, 5'd0, 12'd0));       // Shadow, never stored
        emit(addi_word(5'd1, 5'd0, 12'd99));
        emit(addi_word(5'd3, 5'd0, 12'd3));
        emit(beq_word(5'd1, 5'd3, 13'd8));      // Not taken
        emit(addi_word(5'd4, 5'd0, 12'd4));
        emit(sw_word(5'd3, 5'd0, 12'd4));
        emit(sw_word(5'd4, 5'd0, 12'd8));
        emit(sw_word(5'd1, 5'd0, 12'd12));
        emit_end();
    endtask

    task automatic zero_reg_program();
        emit(addi_word(5'd0, 5'd0, 12'd55));
        emit(addi_word(5'd1, 5'd0, 12'd9));
        emit(r_word(0, 5'd0, 5'd1, 5'd1));
        emit(r_word(0, 5'd2, 5'd0, 5'd1));      // x0 must not be forwarded
        emit(sw_word(5'd0, 5'd0, 12'd0));
        emit(sw_word(5'd2, 5'd0, 12'd4));
        emit_end();
    endtask

    task automatic random_program();
        int         kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int i = 0; i < 40; i++) begin
            kind = int'(random_bits(3) % 32'd6);
            rd   = 5'(random_bits(5));
            rs1  = 5'(random_bits(5));
            if (kind == 5) begin
                emit(addi_word(rd, rs1, 12'(random_bits(12))));
            end else begin
                rs2 = 5'(random_bits(5));
                emit(r_word(kind, rd, rs1, rs2));
            end
        end
        for (int r = 1; r < 32; r++) begin
            emit(sw_word(5'(r), 5'd0, 12'(4 * r)));
        end
        emit_end();
    endtask

    initial begin
        rst_n      = 1'b0;
        lfsr_state = 32'h111e_8859;
        exp_count  = 0;
        pass_count = 0;
        fail_count = 0;
        clear_program();

        begin_test();
        forwarding_program();
        run_program("forwarding");
        begin_test();
        load_use_program();
        run_program("load_use");
        begin_test();
        branch_program();
        run_program("branch");
        begin_test();
        zero_reg_program();
        run_program("x0_writes");
        begin_test();
        random_program();
        run_program("random");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+source
source/rv_core_pkg.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/hazard_unit.sv
source/rv_core.sv
tests/tb_clock_gen.sv
tests/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the rv_core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timescale 1ns/10ps -f filelist.f --top-module tb_rv_core \
    -o sim_rv_core \
    && ./obj_dir/sim_rv_core > sim.log 2>&1 \
    || { echo "Simulation build or run failed"; exit 1; }

cat sim.log
grep -q "^All tests passed$" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
